// ==== verilog.f ====
wb_pkg.sv
soc_map_pkg.sv
wb_interconnect_sharedbus.sv
wb_spramx32.sv
wb_gpio.sv
wb_timer.sv
wb_soc_fabric.sv
tb_wb_soc.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fabric testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_wb_soc -f verilog.f \
  && ./obj_dir/Vtb_wb_soc > sim.log 2>&1
cat sim.log 2>/dev/null
[ -s sim.log ] && ! grep -q "ERRORS FOUND" sim.log && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1

// ==== tb_wb_soc.sv ====
`timescale 1ns/10ps

module tb_wb_soc;

  localparam int RamBytes  = 4096;
  localparam int GpioWidth = 8;
  localparam int MaxWait   = 200;  // cycles

  logic clk, rst_n_i;
  logic m0_cyc_i, m0_stb_i, m0_we_i, m1_cyc_i, m1_stb_i, m1_we_i;
  wb_pkg::wb_adr_t m0_adr_i, m1_adr_i;
  wb_pkg::wb_dat_t m0_dat_w_i, m1_dat_w_i, m0_dat_r_o, m1_dat_r_o;
  wb_pkg::wb_sel_t m0_sel_i, m1_sel_i;
  logic m0_stall_o, m0_ack_o, m0_err_o, m1_stall_o, m1_ack_o, m1_err_o;
  logic [GpioWidth-1:0] gpio_i, gpio_o;
  logic timer_irq_o;

  wb_pkg::wb_dat_t ram_model [RamBytes/4];
  int gnt_order [$];  // masters in the order they got the bus

  wb_soc_fabric #(.RamBytes(RamBytes), .GpioWidth(GpioWidth)) i_dut (.*);

  always #20 clk = ~clk;

  task automatic check_eq(input logic [31:0] act, input logic [31:0] exp, input string what);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, act, exp);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic give_up(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "timeout");
  endtask

  task automatic drive_master(input int m, input logic cyc, input logic stb, input logic we,
                              input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t dat,
                              input wb_pkg::wb_sel_t sel);
    if (m == 0) {m0_cyc_i, m0_stb_i, m0_we_i, m0_adr_i, m0_dat_w_i, m0_sel_i} =
                {cyc, stb, we, adr, dat, sel};
    else        {m1_cyc_i, m1_stb_i, m1_we_i, m1_adr_i, m1_dat_w_i, m1_sel_i} =
                {cyc, stb, we, adr, dat, sel};
  endtask

  // one pipelined transfer where cycles counts clocks from request to response
  task automatic do_transfer(input int m, input logic we, input wb_pkg::wb_adr_t adr,
                             input wb_pkg::wb_dat_t wdat, input wb_pkg::wb_sel_t sel,
                             output wb_pkg::wb_dat_t rdat, output logic ack,
                             output logic err, output int cycles);
    int n;
    @(posedge clk);
    #1;
    drive_master(m, 1'b1, 1'b1, we, adr, wdat, sel);
    cycles = 0;
    n = 0;
    forever begin
      @(negedge clk);
      if (!(m == 0 ? m0_stall_o : m1_stall_o)) break;  // taken at next edge
      @(posedge clk);
      #1;
      cycles++;
      n++;
      if (n > MaxWait) give_up("bus grant");
    end
    gnt_order.push_back(m);
    @(posedge clk);
    #1;
    drive_master(m, 1'b1, 1'b0, we, adr, wdat, sel);
    cycles++;
    n = 0;
    forever begin
      @(negedge clk);
      ack = (m == 0) ? m0_ack_o : m1_ack_o;
      err = (m == 0) ? m0_err_o : m1_err_o;
      if (ack || err) break;
      @(posedge clk);
      #1;
      cycles++;
      n++;
      if (n > MaxWait) give_up("ack or err");
    end
    rdat = (m == 0) ? m0_dat_r_o : m1_dat_r_o;
    @(posedge clk);
    #1;
    drive_master(m, 1'b0, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic wb_write(input int m, input wb_pkg::wb_adr_t adr, input wb_pkg::wb_dat_t dat,
                          input wb_pkg::wb_sel_t sel);
    wb_pkg::wb_dat_t rdat;
    logic ack, err;
    int cycles;
    do_transfer(m, 1'b1, adr, dat, sel, rdat, ack, err, cycles);
    check_eq(ack, 1'b1, "write ack");
    check_eq(err, 1'b0, "write err");
    if (adr < RamBytes) begin
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) ram_model[adr >> 2][8*b +: 8] = dat[8*b +: 8];  // byte merge
      end
    end
  endtask

  task automatic wb_read(input int m, input wb_pkg::wb_adr_t adr, output wb_pkg::wb_dat_t rdat);
    logic ack, err;
    int cycles;
    do_transfer(m, 1'b0, adr, '0, 4'hF, rdat, ack, err, cycles);
    check_eq(ack, 1'b1, "read ack");
    check_eq(err, 1'b0, "read err");
  endtask

  task automatic wait_irq(input logic level);
    int n;
    n = 0;
    forever begin
      @(negedge clk);
      if (timer_irq_o === level) break;
      n++;
      if (n > MaxWait) give_up("timer interrupt level");
    end
  endtask

  task automatic reset_and_latency();
    wb_pkg::wb_dat_t rdat;
    logic ack, err;
    int cycles;
    @(negedge clk);
    check_eq({m0_ack_o, m1_ack_o, m0_err_o, m1_err_o, timer_irq_o}, '0, "responses after reset");
    check_eq({m0_stall_o, m1_stall_o}, 2'b11, "no grant after reset");
    check_eq(gpio_o, '0, "gpio_o after reset");
    wb_write(0, 32'h40, 32'h1234_5678, 4'hF);
    do_transfer(1, 1'b0, 32'h40, '0, 4'hF, rdat, ack, err, cycles);
    check_eq({ack, err}, 2'b10, "lone read response");
    check_eq(cycles, 2, "lone read latency");
    check_eq(rdat, ram_model[16], "lone read data");
  endtask

  task automatic ram_random_rw();
    wb_pkg::wb_adr_t adr;
    wb_pkg::wb_dat_t rdat;
    for (int i = 0; i < 8; i++) begin
      adr = 32'($urandom_range(RamBytes/4 - 1)) << 2;
      wb_write(0, adr, $urandom, 4'hF);
      wb_write(0, adr, $urandom, 4'($urandom_range(14, 1)));  // partial lanes
      wb_read(1, adr, rdat);
      check_eq(rdat, ram_model[adr >> 2], "ram read back");
    end
  endtask

  task automatic collision_rr();
    wb_pkg::wb_dat_t d0, d1, rdat;
    logic a0, a1, e0, e1;
    int c0, c1, prev, winner, last_win;
    for (int i = 0; i < 8; i++) wb_write(0, 32'h100 + 4*i, $urandom, 4'hF);
    for (int k = 0; k < 4; k++) begin
      prev = gnt_order[$];
      fork
        do_transfer(0, 1'b0, 32'h100 + 8*k, '0, 4'hF, d0, a0, e0, c0);
        do_transfer(1, 1'b0, 32'h104 + 8*k, '0, 4'hF, d1, a1, e1, c1);
      join
      check_eq({a0, e0, a1, e1}, 4'b1010, "collision responses");
      check_eq(d0, ram_model[(32'h100 + 8*k) >> 2], "m0 collision data");
      check_eq(d1, ram_model[(32'h104 + 8*k) >> 2], "m1 collision data");
      winner = gnt_order[gnt_order.size() - 2];
      check_eq(winner, 1 - prev, "collision winner");
      check_eq(winner == 0 ? c0 : c1, 2, "winner latency");
      if (k > 0) check_eq(winner, 1 - last_win, "winner alternates");
      last_win = winner;
      wb_read(winner, 32'h100, rdat);  // lone access by the winner
    end
  endtask

  task automatic gpio_loop();
    wb_pkg::wb_dat_t rdat;
    wb_write(0, soc_map_pkg::GpioBase, 32'hA5, 4'h1);
    check_eq(gpio_o, 8'hA5, "gpio_o after write");
    wb_write(1, soc_map_pkg::GpioBase, 32'h5A, 4'hE);  // lane 0 off
    check_eq(gpio_o, 8'hA5, "gpio_o kept without sel 0");
    wb_read(1, soc_map_pkg::GpioBase, rdat);
    check_eq(rdat, 32'hA5, "gpio output register read");
    gpio_i = 8'h3C;
    repeat (4) @(posedge clk);
    #1;
    wb_read(0, soc_map_pkg::GpioBase + 4, rdat);
    check_eq(rdat, 32'h3C, "gpio input read");
  endtask

  task automatic timer_irq();
    wb_pkg::wb_dat_t t1, t2, rdat;
    wb_read(0, soc_map_pkg::TimerBase, t1);
    wb_read(0, soc_map_pkg::TimerBase, t2);
    check_eq(t2 > t1, 1'b1, "mtime increases");
    wb_write(0, soc_map_pkg::TimerBase + 4, t1 + 20, 4'hF);
    wb_read(1, soc_map_pkg::TimerBase + 4, rdat);
    check_eq(rdat, t1 + 20, "mtimecmp read back");
    check_eq(timer_irq_o, 1'b0, "irq before compare");
    wait_irq(1'b1);
    wb_write(1, soc_map_pkg::TimerBase + 4, '1, 4'hF);
    wait_irq(1'b0);
  endtask

  task automatic unmapped_err();
    wb_pkg::wb_dat_t rdat;
    logic ack, err;
    int cycles;
    do_transfer(1, 1'b0, 32'h2000_0000, '0, 4'hF, rdat, ack, err, cycles);
    check_eq({ack, err}, 2'b01, "unmapped read response");
    do_transfer(0, 1'b1, 32'h2000_0040, $urandom, 4'hF, rdat, ack, err, cycles);
    check_eq({ack, err}, 2'b01, "unmapped write response");
    wb_write(0, 32'h80, $urandom, 4'hF);
    wb_read(1, 32'h80, rdat);
    check_eq(rdat, ram_model[32], "ram after error");
  endtask

  initial begin
    void'($urandom(32'haa6ef4bf));
    clk = 1'b0;
    rst_n_i = 1'b0;
    gpio_i = '0;
    drive_master(0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    drive_master(1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    repeat (16) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    reset_and_latency();
    ram_random_rw();
    collision_rr();
    gpio_loop();
    timer_irq();
    unmapped_err();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== wb_soc_fabric.sv ====
`timescale 1ns/10ps

module wb_soc_fabric #(
  parameter int RamBytes  = 4096,
  parameter int GpioWidth = 8
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 m0_cyc_i,
  input  logic                 m0_stb_i,
  input  logic                 m0_we_i,
  input  wb_pkg::wb_adr_t      m0_adr_i,
  input  wb_pkg::wb_dat_t      m0_dat_w_i,
  input  wb_pkg::wb_sel_t      m0_sel_i,
  output wb_pkg::wb_dat_t      m0_dat_r_o,
  output logic                 m0_stall_o,
  output logic                 m0_ack_o,
  output logic                 m0_err_o,
  input  logic                 m1_cyc_i,
  input  logic                 m1_stb_i,
  input  logic                 m1_we_i,
  input  wb_pkg::wb_adr_t      m1_adr_i,
  input  wb_pkg::wb_dat_t      m1_dat_w_i,
  input  wb_pkg::wb_sel_t      m1_sel_i,
  output wb_pkg::wb_dat_t      m1_dat_r_o,
  output logic                 m1_stall_o,
  output logic                 m1_ack_o,
  output logic                 m1_err_o,
  input  logic [GpioWidth-1:0] gpio_i,
  output logic [GpioWidth-1:0] gpio_o,
  output logic                 timer_irq_o
);

  // shared slave bus with stb and the responses split per slave
  logic [soc_map_pkg::NrSlave-1:0] s_stb, s_ack;
  logic s_cyc, s_we;
  wb_pkg::wb_adr_t s_adr;
  wb_pkg::wb_dat_t s_dat_w;
  wb_pkg::wb_sel_t s_sel;
  wb_pkg::wb_dat_t s_dat_r [soc_map_pkg::NrSlave];

  wb_interconnect_sharedbus #(.RamBytes(RamBytes)) i_intercon (
    .clk, .rst_n_i,
    .m0_cyc_i, .m0_stb_i, .m0_we_i, .m0_adr_i, .m0_dat_w_i, .m0_sel_i,
    .m0_dat_r_o, .m0_stall_o, .m0_ack_o, .m0_err_o,
    .m1_cyc_i, .m1_stb_i, .m1_we_i, .m1_adr_i, .m1_dat_w_i, .m1_sel_i,
    .m1_dat_r_o, .m1_stall_o, .m1_ack_o, .m1_err_o,
    .s_stb_o(s_stb), .s_cyc_o(s_cyc), .s_we_o(s_we), .s_adr_o(s_adr),
    .s_dat_w_o(s_dat_w), .s_sel_o(s_sel), .s_dat_r_i(s_dat_r), .s_ack_i(s_ack)
  );

  wb_spramx32 #(.RamBytes(RamBytes)) i_ram (
    .clk, .rst_n_i, .cyc_i(s_cyc), .stb_i(s_stb[soc_map_pkg::RAM_S]), .we_i(s_we),
    .adr_i(s_adr), .dat_w_i(s_dat_w), .sel_i(s_sel), .stall_o(),
    .dat_r_o(s_dat_r[soc_map_pkg::RAM_S]), .ack_o(s_ack[soc_map_pkg::RAM_S])
  );

  wb_gpio #(.GpioWidth(GpioWidth)) i_gpio (
    .clk, .rst_n_i, .cyc_i(s_cyc), .stb_i(s_stb[soc_map_pkg::GPIO_S]), .we_i(s_we),
    .adr_i(s_adr), .dat_w_i(s_dat_w), .sel_i(s_sel), .stall_o(),
    .dat_r_o(s_dat_r[soc_map_pkg::GPIO_S]), .ack_o(s_ack[soc_map_pkg::GPIO_S]),
    .gpio_i, .gpio_o
  );

  wb_timer i_timer (
    .clk, .rst_n_i, .cyc_i(s_cyc), .stb_i(s_stb[soc_map_pkg::TIMER_S]), .we_i(s_we),
    .adr_i(s_adr), .dat_w_i(s_dat_w), .sel_i(s_sel), .stall_o(),
    .dat_r_o(s_dat_r[soc_map_pkg::TIMER_S]), .ack_o(s_ack[soc_map_pkg::TIMER_S]),
    .timer_irq_o
  );

endmodule

// ==== wb_timer.sv ====
`timescale 1ns/10ps

module wb_timer (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            cyc_i,
  input  logic            stb_i,
  input  logic            we_i,
  input  wb_pkg::wb_adr_t adr_i,
  input  wb_pkg::wb_dat_t dat_w_i,
  input  wb_pkg::wb_sel_t sel_i,
  output wb_pkg::wb_dat_t dat_r_o,
  output logic            stall_o,
  output logic            ack_o,
  output logic            timer_irq_o
);

  wb_pkg::wb_dat_t mtime, mtimecmp;
  logic accept;

  assign accept  = cyc_i & stb_i;
  assign stall_o = 1'b0;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mtime       <= '0;
      mtimecmp    <= '1;   // irq stays quiet until software programs it
      ack_o       <= 1'b0;
      timer_irq_o <= 1'b0;
    end else begin
      mtime       <= mtime + 1'b1;
      ack_o       <= accept;
      timer_irq_o <= (mtime >= mtimecmp);
      if (accept && we_i && adr_i[3:2] == 2'd1) begin
        for (int b = 0; b < 4; b++) begin
          if (sel_i[b]) mtimecmp[8*b +: 8] <= dat_w_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      case (adr_i[3:2])
        2'd0:    dat_r_o <= mtime;
        2'd1:    dat_r_o <= mtimecmp;
        default: dat_r_o <= '0;
      endcase
    end
  end

endmodule

// ==== wb_gpio.sv ====
`timescale 1ns/10ps

module wb_gpio #(
  parameter int GpioWidth = 8
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 cyc_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  wb_pkg::wb_adr_t      adr_i,
  input  wb_pkg::wb_dat_t      dat_w_i,
  input  wb_pkg::wb_sel_t      sel_i,
  output wb_pkg::wb_dat_t      dat_r_o,
  output logic                 stall_o,
  output logic                 ack_o,
  input  logic [GpioWidth-1:0] gpio_i,
  output logic [GpioWidth-1:0] gpio_o
);

  logic accept;
  logic [GpioWidth-1:0] in_meta, in_sync;

  assign accept  = cyc_i & stb_i;
  assign stall_o = 1'b0;

  // two flop synchronizer on the pins
  always_ff @(posedge clk) begin
    in_meta <= gpio_i;
    in_sync <= in_meta;
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      gpio_o <= '0;
      ack_o  <= 1'b0;
    end else begin
      ack_o <= accept;
      if (accept && we_i && adr_i[3:2] == 2'd0 && sel_i[0])
        gpio_o <= dat_w_i[GpioWidth-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      case (adr_i[3:2])
        2'd0:    dat_r_o <= 32'(gpio_o);
        2'd1:    dat_r_o <= 32'(in_sync);  // read only
        default: dat_r_o <= '0;
      endcase
    end
  end

endmodule

// ==== wb_spramx32.sv ====
`timescale 1ns/10ps

module wb_spramx32 #(
  parameter int RamBytes = 4096
) (
  input  logic            clk,
  input  logic            rst_n_i,
  input  logic            cyc_i,
  input  logic            stb_i,
  input  logic            we_i,
  input  wb_pkg::wb_adr_t adr_i,
  input  wb_pkg::wb_dat_t dat_w_i,
  input  wb_pkg::wb_sel_t sel_i,
  output wb_pkg::wb_dat_t dat_r_o,
  output logic            stall_o,
  output logic            ack_o
);

  localparam int Words   = RamBytes / 4;
  localparam int IdxBits = $clog2(Words);

  wb_pkg::wb_dat_t mem [Words];
  logic [IdxBits-1:0] idx;
  logic accept;

  assign idx     = adr_i[IdxBits+1:2]; // word address
  assign accept  = cyc_i & stb_i;
  assign stall_o = 1'b0;

  always_ff @(posedge clk) begin
    if (accept) begin
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (sel_i[b]) mem[idx][8*b +: 8] <= dat_w_i[8*b +: 8];
        end
      end
      dat_r_o <= mem[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) ack_o <= 1'b0;
    else          ack_o <= accept;
  end

  // the decoder upstream must keep requests inside the array
  a_idx_range: assert property (@(posedge clk) disable iff (!rst_n_i)
    accept |-> adr_i < 32'(RamBytes));

endmodule

// ==== wb_interconnect_sharedbus.sv ====
`timescale 1ns/10ps

module wb_interconnect_sharedbus #(
  parameter int RamBytes = 4096
) (
  input  logic                                clk,
  input  logic                                rst_n_i,
  // master 0
  input  logic                                m0_cyc_i,
  input  logic                                m0_stb_i,
  input  logic                                m0_we_i,
  input  wb_pkg::wb_adr_t                     m0_adr_i,
  input  wb_pkg::wb_dat_t                     m0_dat_w_i,
  input  wb_pkg::wb_sel_t                     m0_sel_i,
  output wb_pkg::wb_dat_t                     m0_dat_r_o,
  output logic                                m0_stall_o,
  output logic                                m0_ack_o,
  output logic                                m0_err_o,
  // master 1
  input  logic                                m1_cyc_i,
  input  logic                                m1_stb_i,
  input  logic                                m1_we_i,
  input  wb_pkg::wb_adr_t                     m1_adr_i,
  input  wb_pkg::wb_dat_t                     m1_dat_w_i,
  input  wb_pkg::wb_sel_t                     m1_sel_i,
  output wb_pkg::wb_dat_t                     m1_dat_r_o,
  output logic                                m1_stall_o,
  output logic                                m1_ack_o,
  output logic                                m1_err_o,
  // shared slave side
  output logic [soc_map_pkg::NrSlave-1:0]     s_stb_o,
  output logic                                s_cyc_o,
  output logic                                s_we_o,
  output wb_pkg::wb_adr_t                     s_adr_o,
  output wb_pkg::wb_dat_t                     s_dat_w_o,
  output wb_pkg::wb_sel_t                     s_sel_o,
  input  wb_pkg::wb_dat_t                     s_dat_r_i [soc_map_pkg::NrSlave],
  input  logic [soc_map_pkg::NrSlave-1:0]     s_ack_i
);

  logic busy_q;   // a master owns the bus
  logic last_q;   // owner while busy, last winner while idle (1 = m1)
  logic gnt0, gnt1;
  logic cur_cyc, bus_stb;
  logic [soc_map_pkg::NrSlave-1:0] dec_sel;
  logic dec_err;
  logic err_q;
  logic rsp_ack;
  wb_pkg::wb_dat_t rsp_dat;

  assign gnt0    = busy_q & ~last_q;
  assign gnt1    = busy_q & last_q;
  assign cur_cyc = last_q ? m1_cyc_i : m0_cyc_i;

  // round robin that only re-arbitrates once the owner has dropped cyc
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      last_q <= 1'b1; // so m0 wins the first collision
    end else if (!busy_q) begin
      if (m0_cyc_i || m1_cyc_i) begin
        busy_q <= 1'b1;
        last_q <= m1_cyc_i && (!m0_cyc_i || !last_q);
      end
    end else if (!cur_cyc) begin
      busy_q <= 1'b0;
    end
  end

  // granted master drives the shared bus
  assign s_cyc_o   = busy_q & cur_cyc;
  assign bus_stb   = s_cyc_o & (last_q ? m1_stb_i : m0_stb_i);
  assign s_we_o    = last_q ? m1_we_i : m0_we_i;
  assign s_adr_o   = last_q ? m1_adr_i : m0_adr_i;
  assign s_dat_w_o = last_q ? m1_dat_w_i : m0_dat_w_i;
  assign s_sel_o   = last_q ? m1_sel_i : m0_sel_i;

  always_comb begin
    dec_sel = '0;
    if (s_adr_o >= soc_map_pkg::RamBase &&
        s_adr_o < soc_map_pkg::RamBase + 32'(RamBytes))
      dec_sel[soc_map_pkg::RAM_S] = 1'b1;
    else if (s_adr_o >= soc_map_pkg::GpioBase &&
             s_adr_o < soc_map_pkg::GpioBase + soc_map_pkg::GpioSize)
      dec_sel[soc_map_pkg::GPIO_S] = 1'b1;
    else if (s_adr_o >= soc_map_pkg::TimerBase &&
             s_adr_o < soc_map_pkg::TimerBase + soc_map_pkg::TimerSize)
      dec_sel[soc_map_pkg::TIMER_S] = 1'b1;
  end

  assign dec_err = ~|dec_sel;
  assign s_stb_o = {soc_map_pkg::NrSlave{bus_stb}} & dec_sel;

  // unmapped access is swallowed here and answered like a slave would
  always_ff @(posedge clk) begin
    if (!rst_n_i) err_q <= 1'b0;
    else          err_q <= bus_stb & dec_err;
  end

  // and-or mux since only the addressed slave acks
  always_comb begin
    rsp_dat = '0;
    for (int i = 0; i < soc_map_pkg::NrSlave; i++) begin
      if (s_ack_i[i]) rsp_dat = rsp_dat | s_dat_r_i[i];
    end
  end

  assign rsp_ack = |s_ack_i;

  assign m0_dat_r_o = rsp_dat;
  assign m1_dat_r_o = rsp_dat;
  assign m0_ack_o   = gnt0 & rsp_ack;
  assign m1_ack_o   = gnt1 & rsp_ack;
  assign m0_err_o   = gnt0 & err_q;
  assign m1_err_o   = gnt1 & err_q;
  assign m0_stall_o = ~gnt0;  // waiting master is held off here
  assign m1_stall_o = ~gnt1;

  // a response goes back to the master whose request was taken one clock before
  a_m0_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
    (m0_ack_o || m0_err_o) |-> $past(gnt0 && m0_stb_i));
  a_m1_owner: assert property (@(posedge clk) disable iff (!rst_n_i)
    (m1_ack_o || m1_err_o) |-> $past(gnt1 && m1_stb_i));
  a_m0_rsp: assert property (@(posedge clk) disable iff (!rst_n_i) !(m0_ack_o && m0_err_o));
  a_m1_rsp: assert property (@(posedge clk) disable iff (!rst_n_i) !(m1_ack_o && m1_err_o));
  // the and-or response mux relies on one slave answering at a time
  a_ack_onehot: assert property (@(posedge clk) disable iff (!rst_n_i) $onehot0(s_ack_i));

endmodule

// ==== soc_map_pkg.sv ====
// address map of the fabric
// the ram size is a module parameter and is decoded in the interconnect
package soc_map_pkg;

  // slave index that is also the bit position in the slave stb vector
  typedef enum int {
    RAM_S,
    GPIO_S,
    TIMER_S
  } wb_slave_e;

  localparam int NrSlave = 3;

  // base addresses
  localparam wb_pkg::wb_adr_t RamBase   = 32'h0000_0000;
  localparam wb_pkg::wb_adr_t GpioBase  = 32'h1000_0000;
  localparam wb_pkg::wb_adr_t TimerBase = 32'h1002_0000;

  // range sizes in bytes
  localparam wb_pkg::wb_adr_t GpioSize  = 32'h0000_0010;
  localparam wb_pkg::wb_adr_t TimerSize = 32'h0000_0010;

endpackage

// ==== wb_pkg.sv ====
// widths shared by every pipelined wishbone port in the fabric
package wb_pkg;

  // byte address as driven by a master
  typedef logic [31:0] wb_adr_t;

  // one bus word
  typedef logic [31:0] wb_dat_t;

  // one select bit per byte lane of wb_dat_t
  typedef logic [3:0] wb_sel_t;

endpackage
